/* rn_pkg.sv */
package rn_pkg;

   // Group and commit widths
   localparam int ISSUE_W = 2;
   localparam int CMT_W = 2;

   // Register index widths
   localparam int LRF_AW = 5;
   localparam int PRF_AW = 6;

   // Register file sizes
   localparam int N_LRF = 1 << LRF_AW;
   localparam int N_PRF = 1 << PRF_AW;

   // Physical registers not held by the initial identity map
   localparam int FL_DEPTH = N_PRF - N_LRF;

   // Free list index width without the pointer wrap bit
   localparam int FL_AW = $clog2(FL_DEPTH);

   typedef logic [LRF_AW-1:0] lreg_t;
   typedef logic [PRF_AW-1:0] preg_t;

endpackage

/* rn_if.sv */
`timescale 1ns/1ns

// Decoded group from the input buffer into the rename logic
interface rn_group_if;
   logic                                 valid;
   logic                                 ready;
   rn_pkg::lreg_t [rn_pkg::ISSUE_W-1:0]  lrs1;
   rn_pkg::lreg_t [rn_pkg::ISSUE_W-1:0]  lrs2;
   rn_pkg::lreg_t [rn_pkg::ISSUE_W-1:0]  lrd;
   logic [rn_pkg::ISSUE_W-1:0]           lrd_we;

   modport src
   (
      output valid,
      output lrs1,
      output lrs2,
      output lrd,
      output lrd_we,
      input  ready
   );

   modport dst
   (
      input  valid,
      input  lrs1,
      input  lrs2,
      input  lrd,
      input  lrd_we,
      output ready
   );
endinterface

// Renamed group toward the output register
interface rn_result_if;
   logic                                 valid;
   logic                                 ready;
   rn_pkg::preg_t [rn_pkg::ISSUE_W-1:0]  prs1;
   rn_pkg::preg_t [rn_pkg::ISSUE_W-1:0]  prs2;
   rn_pkg::preg_t [rn_pkg::ISSUE_W-1:0]  prd;
   rn_pkg::preg_t [rn_pkg::ISSUE_W-1:0]  pfree;
   logic [rn_pkg::ISSUE_W-1:0]           lrd_we;

   modport src
   (
      output valid,
      output prs1,
      output prs2,
      output prd,
      output pfree,
      output lrd_we,
      input  ready
   );

   modport dst
   (
      input  valid,
      input  prs1,
      input  prs2,
      input  prd,
      input  pfree,
      input  lrd_we,
      output ready
   );
endinterface

// Commit bundle from the reorder buffer without a handshake
interface rn_cmt_if;
   logic [rn_pkg::CMT_W-1:0]             fire;
   rn_pkg::lreg_t [rn_pkg::CMT_W-1:0]    lrd;
   rn_pkg::preg_t [rn_pkg::CMT_W-1:0]    prd;
   logic [rn_pkg::CMT_W-1:0]             prd_we;
   rn_pkg::preg_t [rn_pkg::CMT_W-1:0]    pfree;

   modport src
   (
      output fire,
      output lrd,
      output prd,
      output prd_we,
      output pfree
   );

   modport rat
   (
      input  fire,
      input  lrd,
      input  prd,
      input  prd_we
   );

   modport fl
   (
      input  fire,
      input  prd_we,
      input  pfree
   );
endinterface

/* rn_req_buf.sv */
`timescale 1ns/1ns

module rn_req_buf
(
   input  logic                                 clk,
   input  logic                                 rst_n,
   input  logic                                 rollback,
   input  logic                                 in_valid,
   output logic                                 in_ready,
   input  rn_pkg::lreg_t [rn_pkg::ISSUE_W-1:0]  in_lrs1,
   input  rn_pkg::lreg_t [rn_pkg::ISSUE_W-1:0]  in_lrs2,
   input  rn_pkg::lreg_t [rn_pkg::ISSUE_W-1:0]  in_lrd,
   input  logic [rn_pkg::ISSUE_W-1:0]           in_lrd_we,
   rn_group_if.src                              grp
);
   logic                                 full_q;
   logic                                 load;
   rn_pkg::lreg_t [rn_pkg::ISSUE_W-1:0]  lrs1_q;
   rn_pkg::lreg_t [rn_pkg::ISSUE_W-1:0]  lrs2_q;
   rn_pkg::lreg_t [rn_pkg::ISSUE_W-1:0]  lrd_q;
   logic [rn_pkg::ISSUE_W-1:0]           lrd_we_q;

   // Accept when empty or draining this cycle
   // Nothing enters during a flush
   assign in_ready = ~rollback & (~full_q | grp.ready);
   assign load = in_valid & in_ready;

   always_ff @(posedge clk)
   begin
      if (!rst_n)
         full_q <= 1'b0;
      else if (rollback)
         full_q <= 1'b0;
      else if (load)
         full_q <= 1'b1;
      else if (grp.ready)
         full_q <= 1'b0;
   end

   always_ff @(posedge clk)
   begin
      if (load)
      begin
         lrs1_q   <= in_lrs1;
         lrs2_q   <= in_lrs2;
         lrd_q    <= in_lrd;
         lrd_we_q <= in_lrd_we;
      end
   end

   assign grp.valid  = full_q;
   assign grp.lrs1   = lrs1_q;
   assign grp.lrs2   = lrs2_q;
   assign grp.lrd    = lrd_q;
   assign grp.lrd_we = lrd_we_q;

endmodule

/* rn_rat.sv */
`timescale 1ns/1ns

module rn_rat
(
   input  logic                                 clk,
   input  logic                                 rst_n,
   input  logic                                 rollback,
   input  logic [rn_pkg::ISSUE_W-1:0]           we,
   input  rn_pkg::lreg_t [rn_pkg::ISSUE_W-1:0]  lrs1,
   input  rn_pkg::lreg_t [rn_pkg::ISSUE_W-1:0]  lrs2,
   input  rn_pkg::lreg_t [rn_pkg::ISSUE_W-1:0]  lrd,
   input  logic [rn_pkg::ISSUE_W-1:0]           lrd_we,
   input  rn_pkg::preg_t [rn_pkg::ISSUE_W-1:0]  fl_prd,
   output rn_pkg::preg_t [rn_pkg::ISSUE_W-1:0]  rat_prs1,
   output rn_pkg::preg_t [rn_pkg::ISSUE_W-1:0]  rat_prs2,
   output rn_pkg::preg_t [rn_pkg::ISSUE_W-1:0]  rat_pfree,
   rn_cmt_if.rat                                cmt
);
   // Speculative and committed maps, indexed by logical register
   rn_pkg::preg_t [rn_pkg::N_LRF-1:0]    rat_q;
   rn_pkg::preg_t [rn_pkg::N_LRF-1:0]    arat_q;
   logic [rn_pkg::ISSUE_W-1:0]           spec_we;
   logic [rn_pkg::CMT_W-1:0]             cmt_we;

   assign spec_we = we & lrd_we;
   assign cmt_we  = cmt.fire & cmt.prd_we;

   // Later slots are written last so they win on a shared destination
   always_ff @(posedge clk)
   begin
      if (!rst_n)
      begin
         for (int i = 0; i < rn_pkg::N_LRF; i++)
            rat_q[i] <= rn_pkg::preg_t'(i);
      end
      else if (rollback)
         rat_q <= arat_q;
      else
      begin
         for (int s = 0; s < rn_pkg::ISSUE_W; s++)
         begin
            if (spec_we[s])
               rat_q[lrd[s]] <= fl_prd[s];
         end
      end
   end

   // Committed map follows the reorder buffer in slot order
   always_ff @(posedge clk)
   begin
      if (!rst_n)
      begin
         for (int i = 0; i < rn_pkg::N_LRF; i++)
            arat_q[i] <= rn_pkg::preg_t'(i);
      end
      else
      begin
         for (int c = 0; c < rn_pkg::CMT_W; c++)
         begin
            if (cmt_we[c])
               arat_q[cmt.lrd[c]] <= cmt.prd[c];
         end
      end
   end

   // Table read, then in-group bypass from every older slot
   // The youngest older writer is checked last and takes priority
   always_comb
   begin
      for (int s = 0; s < rn_pkg::ISSUE_W; s++)
      begin
         rat_prs1[s]  = rat_q[lrs1[s]];
         rat_prs2[s]  = rat_q[lrs2[s]];
         rat_pfree[s] = rat_q[lrd[s]];
         for (int x = 0; x < s; x++)
         begin
            // RAW on either source
            if (lrd_we[x] && (lrs1[s] == lrd[x]))
               rat_prs1[s] = fl_prd[x];
            if (lrd_we[x] && (lrs2[s] == lrd[x]))
               rat_prs2[s] = fl_prd[x];
            // On WAW the older slot's new register is freed at commit
            if (lrd_we[x] && lrd_we[s] && (lrd[s] == lrd[x]))
               rat_pfree[s] = fl_prd[x];
         end
      end
   end

endmodule

/* rn_freelist.sv */
`timescale 1ns/1ns

module rn_freelist
(
   input  logic                                 clk,
   input  logic                                 rst_n,
   input  logic                                 rollback,
   input  logic [rn_pkg::ISSUE_W-1:0]           alloc,
   output rn_pkg::preg_t [rn_pkg::ISSUE_W-1:0]  alloc_prd,
   output logic [rn_pkg::FL_AW:0]               free_cnt,
   rn_cmt_if.fl                                 cmt
);
   rn_pkg::preg_t [rn_pkg::FL_DEPTH-1:0]          fl_q;
   // Pointers keep a wrap bit so full and empty differ
   logic [rn_pkg::FL_AW:0]                        tail_q;
   logic [rn_pkg::FL_AW:0]                        head_q;
   logic [rn_pkg::FL_AW:0]                        chead_q;
   logic [rn_pkg::FL_AW:0]                        head_nxt;
   logic [rn_pkg::FL_AW:0]                        tail_nxt;
   logic [rn_pkg::CMT_W-1:0]                      push;
   logic [rn_pkg::CMT_W-1:0][rn_pkg::FL_AW-1:0]   push_idx;

   assign push = cmt.fire & cmt.prd_we;
   assign free_cnt = tail_q - head_q;

   // Allocation from the speculative head
   // A slot that allocates nothing leaves the pointer for the next slot
   always_comb
   begin
      head_nxt = head_q;
      for (int s = 0; s < rn_pkg::ISSUE_W; s++)
      begin
         alloc_prd[s] = fl_q[head_nxt[rn_pkg::FL_AW-1:0]];
         head_nxt = head_nxt + (rn_pkg::FL_AW+1)'(alloc[s]);
      end
   end

   // Freed registers go in at the tail in commit slot order
   always_comb
   begin
      tail_nxt = tail_q;
      for (int c = 0; c < rn_pkg::CMT_W; c++)
      begin
         push_idx[c] = tail_nxt[rn_pkg::FL_AW-1:0];
         tail_nxt = tail_nxt + (rn_pkg::FL_AW+1)'(push[c]);
      end
   end

   // Starts out holding every register above the identity map
   always_ff @(posedge clk)
   begin
      if (!rst_n)
      begin
         for (int i = 0; i < rn_pkg::FL_DEPTH; i++)
            fl_q[i] <= rn_pkg::preg_t'(rn_pkg::N_LRF + i);
      end
      else
      begin
         for (int c = 0; c < rn_pkg::CMT_W; c++)
         begin
            if (push[c])
               fl_q[push_idx[c]] <= cmt.pfree[c];
         end
      end
   end

   always_ff @(posedge clk)
   begin
      if (!rst_n)
      begin
         head_q  <= '0;
         chead_q <= '0;
         tail_q  <= (rn_pkg::FL_AW+1)'(rn_pkg::FL_DEPTH);
      end
      else if (rollback)
         head_q <= chead_q;
      else
      begin
         head_q  <= head_nxt;
         tail_q  <= tail_nxt;
         // One committed allocation per freed register
         chead_q <= chead_q + (tail_nxt - tail_q);
      end
   end

endmodule

/* rn_rename.sv */
`timescale 1ns/1ns

module rn_rename
(
   input  logic      clk,
   input  logic      rst_n,
   input  logic      rollback,
   rn_group_if.dst   grp,
   rn_result_if.src  res,
   rn_cmt_if         cmt
);
   logic [rn_pkg::ISSUE_W-1:0]           alloc;
   rn_pkg::preg_t [rn_pkg::ISSUE_W-1:0]  alloc_prd;
   rn_pkg::preg_t [rn_pkg::ISSUE_W-1:0]  rat_prs1;
   rn_pkg::preg_t [rn_pkg::ISSUE_W-1:0]  rat_prs2;
   rn_pkg::preg_t [rn_pkg::ISSUE_W-1:0]  rat_pfree;
   logic [rn_pkg::FL_AW:0]               free_cnt;
   logic [rn_pkg::FL_AW:0]               n_alloc;
   logic                                 enough;
   logic                                 fire;

   // Destinations wanted by this group
   always_comb
   begin
      n_alloc = '0;
      for (int s = 0; s < rn_pkg::ISSUE_W; s++)
         n_alloc = n_alloc + (rn_pkg::FL_AW+1)'(grp.lrd_we[s]);
   end

   assign enough = (free_cnt >= n_alloc);

   // The group moves only when the output can take it and registers remain
   assign grp.ready = res.ready & enough & ~rollback;
   assign fire = grp.valid & grp.ready;
   assign alloc = grp.lrd_we & {rn_pkg::ISSUE_W{fire}};

   rn_rat i_rat
   (
      .clk       (clk),
      .rst_n     (rst_n),
      .rollback  (rollback),
      .we        ({rn_pkg::ISSUE_W{fire}}),
      .lrs1      (grp.lrs1),
      .lrs2      (grp.lrs2),
      .lrd       (grp.lrd),
      .lrd_we    (grp.lrd_we),
      .fl_prd    (alloc_prd),
      .rat_prs1  (rat_prs1),
      .rat_prs2  (rat_prs2),
      .rat_pfree (rat_pfree),
      .cmt       (cmt)
   );

   rn_freelist i_freelist
   (
      .clk       (clk),
      .rst_n     (rst_n),
      .rollback  (rollback),
      .alloc     (alloc),
      .alloc_prd (alloc_prd),
      .free_cnt  (free_cnt),
      .cmt       (cmt)
   );

   assign res.valid  = fire;
   assign res.prs1   = rat_prs1;
   assign res.prs2   = rat_prs2;
   assign res.pfree  = rat_pfree;
   assign res.lrd_we = grp.lrd_we;

   // Slots without a destination report register zero
   always_comb
   begin
      for (int s = 0; s < rn_pkg::ISSUE_W; s++)
         res.prd[s] = grp.lrd_we[s] ? alloc_prd[s] : '0;
   end

endmodule

/* rn_out_reg.sv */
`timescale 1ns/1ns

module rn_out_reg
(
   input  logic                                 clk,
   input  logic                                 rst_n,
   input  logic                                 rollback,
   rn_result_if.dst                             res,
   output logic                                 out_valid,
   input  logic                                 out_ready,
   output rn_pkg::preg_t [rn_pkg::ISSUE_W-1:0]  out_prs1,
   output rn_pkg::preg_t [rn_pkg::ISSUE_W-1:0]  out_prs2,
   output rn_pkg::preg_t [rn_pkg::ISSUE_W-1:0]  out_prd,
   output rn_pkg::preg_t [rn_pkg::ISSUE_W-1:0]  out_pfree,
   output logic [rn_pkg::ISSUE_W-1:0]           out_lrd_we
);
   logic   valid_q;
   logic   load;

   // Refill in the same cycle the scheduler takes the current group
   assign res.ready = ~valid_q | out_ready;
   assign load = res.valid & res.ready;

   always_ff @(posedge clk)
   begin
      if (!rst_n)
         valid_q <= 1'b0;
      else if (rollback)
         valid_q <= 1'b0;
      else if (res.ready)
         valid_q <= res.valid;
   end

   always_ff @(posedge clk)
   begin
      if (load)
      begin
         out_prs1   <= res.prs1;
         out_prs2   <= res.prs2;
         out_prd    <= res.prd;
         out_pfree  <= res.pfree;
         out_lrd_we <= res.lrd_we;
      end
   end

   assign out_valid = valid_q;

endmodule

/* rn_top.sv */
`timescale 1ns/1ns

module rn_top
(
   input  logic                                 clk,
   input  logic                                 rst_n,
   input  logic                                 rollback,
   input  logic                                 in_valid,
   output logic                                 in_ready,
   input  rn_pkg::lreg_t [rn_pkg::ISSUE_W-1:0]  in_lrs1,
   input  rn_pkg::lreg_t [rn_pkg::ISSUE_W-1:0]  in_lrs2,
   input  rn_pkg::lreg_t [rn_pkg::ISSUE_W-1:0]  in_lrd,
   input  logic [rn_pkg::ISSUE_W-1:0]           in_lrd_we,
   output logic                                 out_valid,
   input  logic                                 out_ready,
   output rn_pkg::preg_t [rn_pkg::ISSUE_W-1:0]  out_prs1,
   output rn_pkg::preg_t [rn_pkg::ISSUE_W-1:0]  out_prs2,
   output rn_pkg::preg_t [rn_pkg::ISSUE_W-1:0]  out_prd,
   output rn_pkg::preg_t [rn_pkg::ISSUE_W-1:0]  out_pfree,
   output logic [rn_pkg::ISSUE_W-1:0]           out_lrd_we,
   input  logic [rn_pkg::CMT_W-1:0]             cmt_fire,
   input  rn_pkg::lreg_t [rn_pkg::CMT_W-1:0]    cmt_lrd,
   input  rn_pkg::preg_t [rn_pkg::CMT_W-1:0]    cmt_prd,
   input  logic [rn_pkg::CMT_W-1:0]             cmt_prd_we,
   input  rn_pkg::preg_t [rn_pkg::CMT_W-1:0]    cmt_pfree
);
   rn_group_if   grp_if ();
   rn_result_if  res_if ();
   rn_cmt_if     cmt_if ();

   // Commit port straight from the reorder buffer
   assign cmt_if.fire   = cmt_fire;
   assign cmt_if.lrd    = cmt_lrd;
   assign cmt_if.prd    = cmt_prd;
   assign cmt_if.prd_we = cmt_prd_we;
   assign cmt_if.pfree  = cmt_pfree;

   rn_req_buf i_req_buf
   (
      .clk       (clk),
      .rst_n     (rst_n),
      .rollback  (rollback),
      .in_valid  (in_valid),
      .in_ready  (in_ready),
      .in_lrs1   (in_lrs1),
      .in_lrs2   (in_lrs2),
      .in_lrd    (in_lrd),
      .in_lrd_we (in_lrd_we),
      .grp       (grp_if.src)
   );

   rn_rename i_rename
   (
      .clk      (clk),
      .rst_n    (rst_n),
      .rollback (rollback),
      .grp      (grp_if.dst),
      .res      (res_if.src),
      .cmt      (cmt_if)
   );

   rn_out_reg i_out_reg
   (
      .clk        (clk),
      .rst_n      (rst_n),
      .rollback   (rollback),
      .res        (res_if.dst),
      .out_valid  (out_valid),
      .out_ready  (out_ready),
      .out_prs1   (out_prs1),
      .out_prs2   (out_prs2),
      .out_prd    (out_prd),
      .out_pfree  (out_pfree),
      .out_lrd_we (out_lrd_we)
   );

endmodule

/* tb_clkgen.sv */
`timescale 1ns/1ns

module tb_clkgen
(
   output logic clk,
   output logic rst_n
);
   // 20 ns period
   initial
   begin
      clk = 1'b0;
      forever #10 clk = ~clk;
   end

   // Reset held over three rising edges and released on a falling edge
   initial
   begin
      rst_n = 1'b0;
      repeat (3) @(posedge clk);
      @(negedge clk);
      rst_n = 1'b1;
   end

endmodule

/* tb_rn_top.sv */
`timescale 1ns/1ns

module tb_rn_top;
   localparam int N_GROUPS = 400;
   localparam int MAX_CYCLES = N_GROUPS * 20;

   logic                                 clk;
   logic                                 rst_n;
   logic                                 rollback;
   logic                                 in_valid;
   logic                                 in_ready;
   rn_pkg::lreg_t [rn_pkg::ISSUE_W-1:0]  in_lrs1;
   rn_pkg::lreg_t [rn_pkg::ISSUE_W-1:0]  in_lrs2;
   rn_pkg::lreg_t [rn_pkg::ISSUE_W-1:0]  in_lrd;
   logic [rn_pkg::ISSUE_W-1:0]           in_lrd_we;
   logic                                 out_valid;
   logic                                 out_ready;
   rn_pkg::preg_t [rn_pkg::ISSUE_W-1:0]  out_prs1;
   rn_pkg::preg_t [rn_pkg::ISSUE_W-1:0]  out_prs2;
   rn_pkg::preg_t [rn_pkg::ISSUE_W-1:0]  out_prd;
   rn_pkg::preg_t [rn_pkg::ISSUE_W-1:0]  out_pfree;
   logic [rn_pkg::ISSUE_W-1:0]           out_lrd_we;
   logic [rn_pkg::CMT_W-1:0]             cmt_fire;
   rn_pkg::lreg_t [rn_pkg::CMT_W-1:0]    cmt_lrd;
   rn_pkg::preg_t [rn_pkg::CMT_W-1:0]    cmt_prd;
   logic [rn_pkg::CMT_W-1:0]             cmt_prd_we;
   rn_pkg::preg_t [rn_pkg::CMT_W-1:0]    cmt_pfree;

   int           seed;
   int           errors;
   int           checked;
   int           cycle;
   int           ncmt;
   int           commits;
   int           rollbacks;
   int           gen_cnt;
   bit           offer;
   logic [31:0]  r;

   // Model of the maps and of every register ever pushed to the free list
   rn_pkg::preg_t  spec_map [rn_pkg::N_LRF];
   rn_pkg::preg_t  arch_map [rn_pkg::N_LRF];
   rn_pkg::preg_t  fl_hist [$];
   int             spec_pos;
   int             cmt_pos;

   // Groups taken at the input, not yet seen at the output
   rn_pkg::lreg_t [rn_pkg::ISSUE_W-1:0]  pend_lrs1 [$];
   rn_pkg::lreg_t [rn_pkg::ISSUE_W-1:0]  pend_lrs2 [$];
   rn_pkg::lreg_t [rn_pkg::ISSUE_W-1:0]  pend_lrd [$];
   logic [rn_pkg::ISSUE_W-1:0]           pend_we [$];

   // Reorder buffer, one entry per instruction
   rn_pkg::lreg_t  rob_lrd [$];
   rn_pkg::preg_t  rob_prd [$];
   rn_pkg::preg_t  rob_pfree [$];
   logic           rob_we [$];

   tb_clkgen i_clkgen
   (
      .clk   (clk),
      .rst_n (rst_n)
   );

   rn_top i_dut
   (
      .clk        (clk),
      .rst_n      (rst_n),
      .rollback   (rollback),
      .in_valid   (in_valid),
      .in_ready   (in_ready),
      .in_lrs1    (in_lrs1),
      .in_lrs2    (in_lrs2),
      .in_lrd     (in_lrd),
      .in_lrd_we  (in_lrd_we),
      .out_valid  (out_valid),
      .out_ready  (out_ready),
      .out_prs1   (out_prs1),
      .out_prs2   (out_prs2),
      .out_prd    (out_prd),
      .out_pfree  (out_pfree),
      .out_lrd_we (out_lrd_we),
      .cmt_fire   (cmt_fire),
      .cmt_lrd    (cmt_lrd),
      .cmt_prd    (cmt_prd),
      .cmt_prd_we (cmt_prd_we),
      .cmt_pfree  (cmt_pfree)
   );

   task automatic check_preg(input string name, input int slot,
                             input rn_pkg::preg_t exp, input rn_pkg::preg_t got);
      if (got !== exp)
      begin
         errors++;
         $display("** Error: %s[%0d] expected 0x%0h, got 0x%0h", name, slot, exp, got);
      end
   endtask

   task automatic new_group();
      for (int s = 0; s < rn_pkg::ISSUE_W; s++)
      begin
         r = $random(seed);
         in_lrs1[s] = r[4:0];
         in_lrs2[s] = r[9:5];
         in_lrd[s] = r[14:10];
         // First groups write nothing so the identity map shows
         in_lrd_we[s] = (gen_cnt < 4) ? 1'b0 : r[15];
      end
      r = $random(seed);
      // Lean slot 1 toward slot 0's destination to reach the bypass paths
      if (r[1:0] == 2'd0)
         in_lrs1[1] = in_lrd[0];
      if (r[3:2] == 2'd0)
         in_lrs2[1] = in_lrd[0];
      if (r[5:4] == 2'd0)
         in_lrd[1] = in_lrd[0];
      gen_cnt++;
   endtask

   task automatic drive_commits(input int n);
      cmt_fire = '0;
      cmt_lrd = '0;
      cmt_prd = '0;
      cmt_prd_we = '0;
      cmt_pfree = '0;
      for (int c = 0; c < n; c++)
      begin
         cmt_fire[c] = 1'b1;
         cmt_lrd[c] = rob_lrd[0];
         cmt_prd[c] = rob_prd[0];
         cmt_pfree[c] = rob_pfree[0];
         cmt_prd_we[c] = rob_we[0];
         if (rob_we[0])
         begin
            arch_map[rob_lrd[0]] = rob_prd[0];
            fl_hist.push_back(rob_pfree[0]);
            cmt_pos++;
         end
         rob_lrd.delete(0);
         rob_prd.delete(0);
         rob_pfree.delete(0);
         rob_we.delete(0);
         commits++;
      end
   endtask

   task automatic rename_and_check();
      rn_pkg::lreg_t [rn_pkg::ISSUE_W-1:0]  lrs1;
      rn_pkg::lreg_t [rn_pkg::ISSUE_W-1:0]  lrs2;
      rn_pkg::lreg_t [rn_pkg::ISSUE_W-1:0]  lrd;
      logic [rn_pkg::ISSUE_W-1:0]           we;
      rn_pkg::preg_t                        prd;
      rn_pkg::preg_t                        pfree;
      if (pend_we.size() == 0)
      begin
         errors++;
         $display("Output group appeared with no accepted input group behind it");
         return;
      end
      lrs1 = pend_lrs1.pop_front();
      lrs2 = pend_lrs2.pop_front();
      lrd = pend_lrd.pop_front();
      we = pend_we.pop_front();
      if (out_lrd_we !== we)
      begin
         errors++;
         $display("** Error: out_lrd_we expected 0x%0h, got 0x%0h", we, out_lrd_we);
      end
      // Slots rename in program order, so slot 1 sees slot 0's new mapping
      for (int s = 0; s < rn_pkg::ISSUE_W; s++)
      begin
         prd = '0;
         pfree = spec_map[lrd[s]];
         check_preg("out_prs1", s, spec_map[lrs1[s]], out_prs1[s]);
         check_preg("out_prs2", s, spec_map[lrs2[s]], out_prs2[s]);
         if (we[s])
         begin
            if (spec_pos >= fl_hist.size())
            begin
               errors++;
               $display("Destination renamed while the model free list was empty");
            end
            else
               prd = fl_hist[spec_pos];
            spec_pos++;
            check_preg("out_pfree", s, pfree, out_pfree[s]);
            spec_map[lrd[s]] = prd;
         end
         check_preg("out_prd", s, prd, out_prd[s]);
         rob_lrd.push_back(lrd[s]);
         rob_prd.push_back(prd);
         rob_pfree.push_back(pfree);
         rob_we.push_back(we[s]);
      end
      checked++;
   endtask

   task automatic do_rollback();
      spec_map = arch_map;
      spec_pos = cmt_pos;
      pend_lrs1.delete();
      pend_lrs2.delete();
      pend_lrd.delete();
      pend_we.delete();
      rob_lrd.delete();
      rob_prd.delete();
      rob_pfree.delete();
      rob_we.delete();
      rollbacks++;
   endtask

   initial
   begin
      seed = 32'h51d1_5b30;
      errors = 0;
      checked = 0;
      cycle = 0;
      commits = 0;
      rollbacks = 0;
      gen_cnt = 0;
      offer = 1'b0;
      spec_pos = 0;
      cmt_pos = 0;
      rollback = 1'b0;
      in_valid = 1'b0;
      in_lrs1 = '0;
      in_lrs2 = '0;
      in_lrd = '0;
      in_lrd_we = '0;
      out_ready = 1'b0;
      drive_commits(0);
      for (int i = 0; i < rn_pkg::N_LRF; i++)
      begin
         spec_map[i] = rn_pkg::preg_t'(i);
         arch_map[i] = rn_pkg::preg_t'(i);
      end
      for (int i = 0; i < rn_pkg::FL_DEPTH; i++)
         fl_hist.push_back(rn_pkg::preg_t'(rn_pkg::N_LRF + i));

      wait (rst_n === 1'b1);
      @(negedge clk);
      #5;
      if ((in_ready !== 1'b1) || (out_valid !== 1'b0))
      begin
         errors++;
         $display("After reset the stage is not empty and ready for input");
      end

      while ((checked < N_GROUPS) && (cycle < MAX_CYCLES))
      begin
         @(negedge clk);
         cycle++;
         ncmt = 0;
         r = $random(seed);
         // Commits pause in alternate windows so the free list runs dry
         if ((cycle % 128) < 64)
            ncmt = int'(r % 32'd3);
         if (ncmt > rob_lrd.size())
            ncmt = rob_lrd.size();
         drive_commits(ncmt);
         r = $random(seed);
         rollback = (ncmt == 0) && ((r % 32'd40) == 32'd0);
         if (!offer)
         begin
            r = $random(seed);
            if (r[1:0] != 2'd0)
            begin
               new_group();
               offer = 1'b1;
            end
         end
         in_valid = offer;
         r = $random(seed);
         // Scheduler stalls about one cycle in four and never takes a flushed group
         out_ready = !rollback && (r[1:0] != 2'd0);

         // Handshakes are settled well before the next rising edge
         #5;
         if (rollback)
            do_rollback();
         else
         begin
            if (out_valid && out_ready)
               rename_and_check();
            if (in_valid && in_ready)
            begin
               pend_lrs1.push_back(in_lrs1);
               pend_lrs2.push_back(in_lrs2);
               pend_lrd.push_back(in_lrd);
               pend_we.push_back(in_lrd_we);
               offer = 1'b0;
            end
         end
      end

      if (checked < N_GROUPS)
         $display("Timeout after %0d cycles with only %0d groups renamed", cycle, checked);
      $display("Groups %0d, commits %0d, rollbacks %0d, errors %0d",
               checked, commits, rollbacks, errors);
      if ((errors == 0) && (checked == N_GROUPS))
         $display("Test passed");
      else
         $display("Test failed");
      $finish;
   end

endmodule

/* rn_top.f */
rn_pkg.sv
rn_if.sv
rn_req_buf.sv
rn_rat.sv
rn_freelist.sv
rn_rename.sv
rn_out_reg.sv
rn_top.sv
tb_clkgen.sv
tb_rn_top.sv

/* run.sh */
#!/bin/bash
# Build and run the rename stage testbench with Verilator
cd "$(dirname "$0")" &&
verilator --binary --top-module tb_rn_top -f rn_top.f -o sim_rn_top &&
./obj_dir/sim_rn_top | tee /dev/stderr | grep -q "Test passed" &&
echo "PASS" && exit 0 ||
{ echo "FAIL"; exit 1; }
